// ==== pipe_pkg.sv ====
/*
 * pipe_pkg
 * sizes, opcode encoding and packed types shared by the
 * five-stage pipeline and its trace unit
 */
package pipe_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int data_w    = 16;
    localparam int reg_count = 8;
    localparam int mem_depth = 16;
    localparam int tag_w     = 3;
    localparam int stamp_w   = 16;

    // derived widths
    localparam int reg_idx_w = $clog2(reg_count);
    localparam int addr_w    = $clog2(mem_depth);
    // op_ldi immediate, zero-extended to data_w
    localparam int imm_w     = 8;

    ////////////////////
    // instruction
    ////////////////////
    typedef enum logic [2:0] {
        op_nop = 3'd0,
        op_add = 3'd1,
        op_sub = 3'd2,
        op_and = 3'd3,
        op_xor = 3'd4,
        op_ldi = 3'd5,
        op_ld  = 3'd6,
        op_st  = 3'd7
    } opcode_e;

    // opcode in the top bits, spare nibble at the bottom
    typedef struct packed {
        opcode_e              opcode;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [3:0]           spare;
    } instr_t;

    ////////////////////
    // stage traffic
    ////////////////////
    typedef struct packed {
        logic              valid;
        logic [tag_w-1:0]  tag;
        instr_t            instr;
        logic [data_w-1:0] operand_a;
        logic [data_w-1:0] operand_b;
        logic [data_w-1:0] result;
    } stage_t;

    // one record per retired instruction
    typedef struct packed {
        logic [tag_w-1:0]   tag;
        instr_t             instr;
        logic [data_w-1:0]  result;
        logic               writes_reg;
        logic [stamp_w-1:0] fetch_stamp;
        logic [stamp_w-1:0] decode_stamp;
        logic [stamp_w-1:0] execute_stamp;
        logic [stamp_w-1:0] memory_stamp;
        logic [stamp_w-1:0] wb_stamp;
        logic [stamp_w-1:0] stall_cycles;
    } retire_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_slot_t;

    // occupancy of every stage as seen by the trace unit
    typedef struct packed {
        tag_slot_t fetch;
        tag_slot_t decode;
        tag_slot_t execute;
        tag_slot_t memory;
        tag_slot_t wb;
    } stage_tags_t;

    // everything but nop and store lands in rd
    function automatic logic writes_reg(opcode_e op);
        return (op != op_nop) && (op != op_st);
    endfunction

endpackage

// ==== fetch_stage.sv ====
/*
 * fetch_stage
 * accepts the instruction stream, tags each instruction in
 * issue order and holds it until decode can take it
 */
module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  pipe_pkg::instr_t in_instr,
    output logic             in_ready,
    input  logic             advance,
    input  logic             hazard,
    output pipe_pkg::stage_t fetch_out
);
    import pipe_pkg::*;

    logic             run_q;
    logic             valid_q;
    // last tag handed out, so the next one is tag_q + 1
    logic [tag_w-1:0] tag_q;
    instr_t           instr_q;

    // room when the register is empty or moves on this cycle
    assign in_ready = run_q && advance && (!valid_q || !hazard);

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q   <= 1'b0;
            valid_q <= 1'b0;
            tag_q   <= '1;
        end else begin
            run_q <= 1'b1;
            if (in_ready) begin
                valid_q <= in_valid;
                // tags wrap modulo 8
                if (in_valid) begin
                    tag_q <= tag_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            instr_q <= in_instr;
        end
    end

    always_comb begin
        fetch_out       = '0;
        fetch_out.valid = valid_q;
        fetch_out.tag   = tag_q;
        fetch_out.instr = instr_q;
    end

endmodule

// ==== decode_stage.sv ====
/*
 * decode_stage
 * register file with write-through from writeback, operand read,
 * and read-after-write stall against execute and memory
 */
module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  pipe_pkg::stage_t fetch_in,
    input  logic             advance,
    input  pipe_pkg::stage_t ex_dest,
    input  pipe_pkg::stage_t mem_dest,
    input  pipe_pkg::stage_t wb_in,
    output logic             hazard,
    output pipe_pkg::stage_t decode_out
);
    import pipe_pkg::*;

    logic [data_w-1:0] regs [reg_count];
    instr_t            ins;
    logic              wb_writes;
    logic [data_w-1:0] rs1_val;
    logic [data_w-1:0] rs2_val;
    logic              valid_q;
    stage_t            dec_next;
    stage_t            dec_q;

    // rd of a live register-writing instruction hits rs1 or rs2
    function automatic logic src_match(stage_t dst, instr_t src);
        return dst.valid && writes_reg(dst.instr.opcode) &&
               ((dst.instr.rd == src.rs1) || (dst.instr.rd == src.rs2));
    endfunction

    assign ins       = fetch_in.instr;
    assign wb_writes = wb_in.valid && writes_reg(wb_in.instr.opcode);
    // writeback needs no stall thanks to write-through
    assign hazard    = fetch_in.valid && (src_match(ex_dest, ins) || src_match(mem_dest, ins));

    ////////////////////
    // register file
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_writes) begin
            regs[wb_in.instr.rd] <= wb_in.result;
        end
    end

    // operand read, writeback value wins over the array
    always_comb begin
        rs1_val = regs[ins.rs1];
        rs2_val = regs[ins.rs2];
        if (wb_writes && (wb_in.instr.rd == ins.rs1)) begin
            rs1_val = wb_in.result;
        end
        if (wb_writes && (wb_in.instr.rd == ins.rs2)) begin
            rs2_val = wb_in.result;
        end
    end

    always_comb begin
        dec_next           = fetch_in;
        // a stalled instruction leaves a bubble behind in execute
        dec_next.valid     = fetch_in.valid && !hazard;
        dec_next.operand_a = rs1_val;
        dec_next.operand_b = rs2_val;
        if (ins.opcode == op_ldi) begin
            dec_next.operand_b = {{(data_w - imm_w){1'b0}}, ins[imm_w-1:0]};
        end
        dec_next.result    = '0;
    end

    ////////////////////
    // decode/execute register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= dec_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dec_q <= dec_next;
        end
    end

    always_comb begin
        decode_out       = dec_q;
        decode_out.valid = valid_q;
    end

endmodule

// ==== execute_stage.sv ====
/*
 * execute_stage
 * ALU and address pass-through into the execute/memory register
 */
module execute_stage (
    input  logic             clk,
    input  logic             rst,
    input  pipe_pkg::stage_t decode_in,
    input  logic             advance,
    output pipe_pkg::stage_t ex_out
);
    import pipe_pkg::*;

    stage_t ex_next;
    stage_t ex_q;
    logic   valid_q;

    always_comb begin
        ex_next = decode_in;
        case (decode_in.instr.opcode)
            op_add: ex_next.result = decode_in.operand_a + decode_in.operand_b;
            op_sub: ex_next.result = decode_in.operand_a - decode_in.operand_b;
            op_and: ex_next.result = decode_in.operand_a & decode_in.operand_b;
            op_xor: ex_next.result = decode_in.operand_a ^ decode_in.operand_b;
            // immediate already sits in operand_b
            op_ldi: ex_next.result = decode_in.operand_b;
            // loads and stores carry the address on
            op_ld,
            op_st:  ex_next.result = decode_in.operand_a;
            default: ex_next.result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= decode_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_q <= ex_next;
        end
    end

    always_comb begin
        ex_out       = ex_q;
        ex_out.valid = valid_q;
    end

endmodule

// ==== memory_stage.sv ====
/*
 * memory_stage
 * data memory access, output register is the writeback stage
 */
module memory_stage (
    input  logic             clk,
    input  logic             rst,
    input  pipe_pkg::stage_t ex_in,
    input  logic             advance,
    output pipe_pkg::stage_t wb_out
);
    import pipe_pkg::*;

    logic [data_w-1:0] dmem [mem_depth];
    logic [addr_w-1:0] addr;
    stage_t            wb_next;
    stage_t            wb_q;
    logic              valid_q;

    // low bits of the register value select the word
    assign addr = ex_in.result[addr_w-1:0];

    // store lands once, as the instruction leaves memory
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (advance && ex_in.valid && (ex_in.instr.opcode == op_st)) begin
            dmem[addr] <= ex_in.operand_b;
        end
    end

    always_comb begin
        wb_next = ex_in;
        if (ex_in.instr.opcode == op_ld) begin
            wb_next.result = dmem[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= ex_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_q <= wb_next;
        end
    end

    always_comb begin
        wb_out       = wb_q;
        wb_out.valid = valid_q;
    end

endmodule

// ==== trace_unit.sv ====
/*
 * trace_unit
 * stamps each tagged instruction on entry to every stage, counts its
 * decode stall cycles and emits one retire record from writeback
 */
module trace_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  pipe_pkg::stage_tags_t tags,
    input  pipe_pkg::stage_t      wb_in,
    input  logic                  advance,
    input  logic                  hazard,
    output logic                  retire_valid,
    output pipe_pkg::retire_t     retire_rec,
    input  logic                  retire_ready
);
    import pipe_pkg::*;

    logic [stamp_w-1:0] cycle;
    // one entry per tag
    logic [stamp_w-1:0] fetch_tab  [2**tag_w];
    logic [stamp_w-1:0] decode_tab [2**tag_w];
    logic [stamp_w-1:0] ex_tab     [2**tag_w];
    logic [stamp_w-1:0] mem_tab    [2**tag_w];
    logic [stamp_w-1:0] stall_tab  [2**tag_w];
    // set when the stage kept the same instruction across the last edge
    logic               pipe_hold_q;
    logic               dec_hold_q;
    logic               wb_hold_q;
    logic               dec_held;
    logic [stamp_w-1:0] wb_stamp;
    logic [stamp_w-1:0] wb_stamp_q;

    // zero in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // decode is held by a hazard or by retire back-pressure
    assign dec_held = tags.decode.valid && (hazard || !advance);

    ////////////////////
    // hold history
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_hold_q <= 1'b0;
            dec_hold_q  <= 1'b0;
            wb_hold_q   <= 1'b0;
        end else begin
            pipe_hold_q <= !advance;
            dec_hold_q  <= dec_held;
            wb_hold_q   <= tags.wb.valid && !retire_ready;
        end
    end

    ////////////////////
    // stamp table
    ////////////////////
    always_ff @(posedge clk) begin
        // acceptance is the fetch cycle, it never repeats
        if (tags.fetch.valid) begin
            fetch_tab[tags.fetch.tag] <= cycle;
        end
        if (tags.decode.valid && !dec_hold_q) begin
            decode_tab[tags.decode.tag] <= cycle;
        end
        // restart the count on entry, add one per held cycle
        if (tags.decode.valid) begin
            stall_tab[tags.decode.tag] <= (dec_hold_q ? stall_tab[tags.decode.tag] : '0)
                                          + stamp_w'(dec_held);
        end
        if (tags.execute.valid && !pipe_hold_q) begin
            ex_tab[tags.execute.tag] <= cycle;
        end
        if (tags.memory.valid && !pipe_hold_q) begin
            mem_tab[tags.memory.tag] <= cycle;
        end
    end

    // the record is live in the first wb cycle, so take that stamp directly
    assign wb_stamp = wb_hold_q ? wb_stamp_q : cycle;

    always_ff @(posedge clk) begin
        wb_stamp_q <= wb_stamp;
    end

    ////////////////////
    // retire record
    ////////////////////
    assign retire_valid = wb_in.valid;

    // stable under back-pressure since every source is held
    always_comb begin
        retire_rec.tag           = tags.wb.tag;
        retire_rec.instr         = wb_in.instr;
        retire_rec.result        = wb_in.result;
        retire_rec.writes_reg    = writes_reg(wb_in.instr.opcode);
        retire_rec.fetch_stamp   = fetch_tab[tags.wb.tag];
        retire_rec.decode_stamp  = decode_tab[tags.wb.tag];
        retire_rec.execute_stamp = ex_tab[tags.wb.tag];
        retire_rec.memory_stamp  = mem_tab[tags.wb.tag];
        retire_rec.wb_stamp      = wb_stamp;
        retire_rec.stall_cycles  = stall_tab[tags.wb.tag];
    end

endmodule

// ==== pipe_top.sv ====
/*
 * pipe_top
 * five-stage in-order pipeline with its trace unit, stream in
 * and retire records out
 */
module pipe_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  pipe_pkg::instr_t  in_instr,
    output logic              in_ready,
    output logic              retire_valid,
    output pipe_pkg::retire_t retire_rec,
    input  logic              retire_ready
);
    import pipe_pkg::*;

    stage_t      fetch_out;
    stage_t      decode_out;
    stage_t      ex_out;
    stage_t      wb_out;
    stage_tags_t tags;
    logic        advance;
    logic        hazard;

    // a record waiting on retire_ready freezes every stage
    assign advance = !(retire_valid && !retire_ready);

    // fetch slot is the accept cycle, its tag is the one about to be given
    assign tags.fetch.valid   = in_valid && in_ready;
    assign tags.fetch.tag     = fetch_out.tag + 1'b1;
    assign tags.decode.valid  = fetch_out.valid;
    assign tags.decode.tag    = fetch_out.tag;
    assign tags.execute.valid = decode_out.valid;
    assign tags.execute.tag   = decode_out.tag;
    assign tags.memory.valid  = ex_out.valid;
    assign tags.memory.tag    = ex_out.tag;
    assign tags.wb.valid      = wb_out.valid;
    assign tags.wb.tag        = wb_out.tag;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .advance   (advance),
        .hazard    (hazard),
        .fetch_out (fetch_out)
    );

    // execute and memory registers feed back as hazard sources
    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .fetch_in   (fetch_out),
        .advance    (advance),
        .ex_dest    (decode_out),
        .mem_dest   (ex_out),
        .wb_in      (wb_out),
        .hazard     (hazard),
        .decode_out (decode_out)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .decode_in (decode_out),
        .advance   (advance),
        .ex_out    (ex_out)
    );

    memory_stage u_memory (
        .clk     (clk),
        .rst     (rst),
        .ex_in   (ex_out),
        .advance (advance),
        .wb_out  (wb_out)
    );

    trace_unit u_trace (
        .clk          (clk),
        .rst          (rst),
        .tags         (tags),
        .wb_in        (wb_out),
        .advance      (advance),
        .hazard       (hazard),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec),
        .retire_ready (retire_ready)
    );

endmodule

// ==== tb_pipe.sv ====
/*
 * tb_pipe
 * random instruction stream through the five-stage pipeline, an ISA
 * model that predicts every retire record, and stamp checks per record
 */
module tb_pipe;
    timeunit 1ns;
    timeprecision 1ps;

    import pipe_pkg::*;

    localparam int n_instr        = 300;
    localparam int timeout_cycles = n_instr * 20;
    localparam int drain_cycles   = 10;
    localparam int clk_half       = 50;

    logic    clk;
    logic    rst;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_ready;
    logic    retire_valid;
    retire_t retire_rec;
    logic    retire_ready;

    // architectural state of the ISA model
    logic [data_w-1:0] model_regs [reg_count];
    logic [data_w-1:0] model_mem  [mem_depth];
    // expected records in issue order, fetch_stamp holds the accept cycle
    retire_t           exp_q [$];
    // last two retired records, enough to see execute and memory
    retire_t           hist [$];
    // retire_ready as driven in each cycle
    bit                ready_log [timeout_cycles + drain_cycles + 2];

    int      tb_cycle;
    int      issued;
    int      retired;
    // record on the retire port was refused last cycle
    bit      hold_pending;
    retire_t held_rec;
    // first cycle the current record showed on the retire port
    int      seen_cycle;

    pipe_top uut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec),
        .retire_ready (retire_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    ////////////////////
    // error reporting
    ////////////////////
    task automatic report_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    ////////////////////
    // ISA model
    ////////////////////
    function automatic instr_t random_instr();
        logic [15:0] bits;
        bits = 16'($urandom);
        return instr_t'(bits);
    endfunction

    // executes one instruction in issue order and queues its record
    task automatic model_issue(instr_t ins, int cyc);
        retire_t           exp;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        a = model_regs[ins.rs1];
        b = model_regs[ins.rs2];
        exp = '0;
        exp.tag         = tag_w'(issued);
        exp.instr       = ins;
        exp.fetch_stamp = stamp_w'(cyc);
        exp.writes_reg  = 1'b1;
        case (ins.opcode)
            op_add: exp.result = a + b;
            op_sub: exp.result = a - b;
            op_and: exp.result = a & b;
            op_xor: exp.result = a ^ b;
            // low byte of the instruction, zero-extended
            op_ldi: exp.result = data_w'(ins[imm_w-1:0]);
            // address is the low bits of rs1
            op_ld:  exp.result = model_mem[a[addr_w-1:0]];
            op_st: begin
                exp.result     = a;
                exp.writes_reg = 1'b0;
                model_mem[a[addr_w-1:0]] = b;
            end
            default: begin
                exp.result     = '0;
                exp.writes_reg = 1'b0;
            end
        endcase
        if (exp.writes_reg) begin
            model_regs[ins.rd] = exp.result;
        end
        exp_q.push_back(exp);
        issued++;
    endtask

    // an earlier writer of rs1 or rs2 sat in execute or memory at cyc
    function automatic bit hazard_at(instr_t ins, int cyc);
        bit hit;
        hit = 1'b0;
        foreach (hist[k]) begin
            if (hist[k].writes_reg &&
                ((hist[k].instr.rd == ins.rs1) || (hist[k].instr.rd == ins.rs2)) &&
                (int'(hist[k].execute_stamp) <= cyc) && (cyc < int'(hist[k].wb_stamp))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_result(retire_t got, retire_t exp);
        if (got.tag !== exp.tag) begin
            report_error($sformatf("tag %0d, expected %0d", got.tag, exp.tag));
        end else if (got.instr !== exp.instr) begin
            report_error($sformatf("tag %0d instr %h, expected %h",
                                   exp.tag, got.instr, exp.instr));
        end else if (got.result !== exp.result) begin
            report_error($sformatf("tag %0d %s result %h, expected %h",
                                   exp.tag, exp.instr.opcode.name(), got.result, exp.result));
        end else if (got.writes_reg !== exp.writes_reg) begin
            report_error($sformatf("tag %0d writes_reg %b, expected %b",
                                   exp.tag, got.writes_reg, exp.writes_reg));
        end
    endtask

    task automatic check_stamps(retire_t got, retire_t exp);
        int f;
        int d;
        int e;
        int m;
        int w;
        int s;
        int t;
        bit steady;
        f = got.fetch_stamp;
        d = got.decode_stamp;
        e = got.execute_stamp;
        m = got.memory_stamp;
        w = got.wb_stamp;
        s = got.stall_cycles;
        // no refused record between execute entry and retire
        steady = 1'b1;
        for (t = e; t < w; t++) begin
            if (!ready_log[t]) begin
                steady = 1'b0;
            end
        end
        if (f != int'(exp.fetch_stamp)) begin
            report_error($sformatf("tag %0d fetch_stamp %0d, accepted in cycle %0d",
                                   got.tag, f, exp.fetch_stamp));
        end else if (d != f + 1) begin
            report_error($sformatf("tag %0d decode_stamp %0d, expected %0d", got.tag, d, f + 1));
        end else if (!((e > d) && (m > e) && (w > m))) begin
            report_error($sformatf("tag %0d stamps not increasing %0d %0d %0d %0d",
                                   got.tag, d, e, m, w));
        end else if (w != seen_cycle) begin
            report_error($sformatf("tag %0d wb_stamp %0d, first shown in cycle %0d",
                                   got.tag, w, seen_cycle));
        end else if (s != e - d - 1) begin
            report_error($sformatf("tag %0d stall_cycles %0d, expected %0d",
                                   got.tag, s, e - d - 1));
        end else if (steady && ((m != e + 1) || (w != m + 1))) begin
            report_error($sformatf("tag %0d stamps %0d %0d %0d without back-pressure",
                                   got.tag, e, m, w));
        end else if (hazard_at(got.instr, d) && (s == 0)) begin
            report_error($sformatf("tag %0d read a pending rd but stall_cycles is 0", got.tag));
        end else if (!hazard_at(got.instr, d) && ready_log[d] && (s != 0)) begin
            report_error($sformatf("tag %0d stall_cycles %0d with no hazard", got.tag, s));
        end
    endtask

    task automatic check_held(logic valid, retire_t got, retire_t held);
        if (valid !== 1'b1) begin
            report_error($sformatf("retire_valid dropped before tag %0d was taken", held.tag));
        end else if (got !== held) begin
            report_error($sformatf("retire_rec of tag %0d changed under back-pressure",
                                   held.tag));
        end
    endtask

    ////////////////////
    // per-cycle stimulus and monitor
    ////////////////////
    task automatic retire_side();
        retire_t exp;
        if (hold_pending) begin
            check_held(retire_valid, retire_rec, held_rec);
        end else if (retire_valid) begin
            seen_cycle = tb_cycle;
        end
        if (retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                report_error($sformatf("tag %0d retired with nothing outstanding",
                                       retire_rec.tag));
            end else begin
                exp = exp_q.pop_front();
                check_result(retire_rec, exp);
                check_stamps(retire_rec, exp);
                hist.push_back(retire_rec);
                if (hist.size() > 2) begin
                    void'(hist.pop_front());
                end
                retired++;
            end
        end
        hold_pending = retire_valid && !retire_ready;
        held_rec     = retire_rec;
    endtask

    task automatic issue_side(bit allow_new);
        if (in_valid && in_ready) begin
            model_issue(in_instr, tb_cycle);
        end
        // in_valid and in_instr hold until the transfer
        if (!in_valid || in_ready) begin
            if (allow_new && (issued < n_instr) && (($urandom % 4) != 0)) begin
                in_valid <= 1'b1;
                in_instr <= random_instr();
            end else begin
                in_valid <= 1'b0;
            end
        end
    endtask

    // sampled right after the rising edge, all drives non-blocking
    task automatic step_cycle(bit run);
        ready_log[tb_cycle] = retire_ready;
        retire_side();
        issue_side(run);
        if (run) begin
            retire_ready <= (($urandom % 4) != 0);
        end else begin
            retire_ready <= 1'b1;
        end
        tb_cycle++;
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        void'($urandom(32'h1442));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        retire_ready = 1'b0;
        issued       = 0;
        retired      = 0;
        hold_pending = 1'b0;
        seen_cycle   = 0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < mem_depth; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // cycle 0 is the one right after reset, as in the trace unit
        tb_cycle = 0;
        while (retired < n_instr) begin
            @(posedge clk);
            step_cycle(1'b1);
            if (tb_cycle >= timeout_cycles) begin
                $display("timeout: %0d of %0d instructions retired after %0d cycles",
                         retired, n_instr, tb_cycle);
                $display("TESTS FAILED");
                $fatal(1, "cycle limit reached");
            end
        end
        // idle stream, any further record would be a duplicate
        repeat (drain_cycles) begin
            @(posedge clk);
            step_cycle(1'b0);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
trace_unit.sv
pipe_top.sv
tb_pipe.sv
